//--- common/tpl_dac_pkg.sv
// Fixed at two channels, two 16-bit samples per beat and two lanes of four octets; widths are not rescaled
package tpl_dac_pkg;

  // ********************
  // Geometry
  // ********************
  localparam int num_channels     = 2;
  localparam int samples_per_beat = 2;
  localparam int sample_width     = 16;
  localparam int num_lanes        = 2;
  localparam int octets_per_beat  = 4;
  localparam int link_width       = num_lanes * octets_per_beat * 8;
  localparam int chan_width       = samples_per_beat * sample_width;

  // Set to 0 to keep the external arm path permanently inactive
  localparam bit ext_sync_enable = 1'b1;

  // ********************
  // Data types
  // ********************
  typedef logic [sample_width-1:0] sample_t;

  // Sample 0 sits in the low half and is the earlier one
  typedef logic [chan_width-1:0] chan_data_t;

  typedef logic [link_width-1:0] link_data_t;

  // Per channel data source select where unlisted codes give zero data
  typedef logic [3:0] data_sel_t;

  localparam data_sel_t sel_pattern = 4'd0;
  localparam data_sel_t sel_dma     = 4'd2;
  localparam data_sel_t sel_zero    = 4'd3;
  localparam data_sel_t sel_pn7     = 4'd6;
  localparam data_sel_t sel_pn15    = 4'd7;

  // Crossbar source index where out of range values select zero
  typedef logic [7:0] src_sel_t;

  // ********************
  // PN seeds
  // ********************
  localparam logic [6:0]  pn7_seed  = 7'h7f;
  localparam logic [14:0] pn15_seed = 15'h7fff;

endpackage

//--- rtl/tpl_dac_sync.sv
// External trigger is recognised one clock later than arm and disarm edges, disarm always wins
`timescale 1ns/100ps

module tpl_dac_sync (
  input  logic clk,
  input  logic reset,
  input  logic sync,
  input  logic sync_in,
  input  logic sync_manual_req,
  input  logic ext_sync_arm,
  input  logic ext_sync_disarm,
  output logic sync_int,
  output logic sync_in_status
);

  logic arm_d;
  logic disarm_d;
  logic trig_d1;
  logic trig_d2;
  logic armed;

  // Edge detection against one cycle delayed copies
  always_ff @(posedge clk) begin
    if (reset) begin
      arm_d    <= 1'b0;
      disarm_d <= 1'b0;
      trig_d1  <= 1'b0;
      trig_d2  <= 1'b0;
    end else begin
      arm_d    <= ext_sync_arm;
      disarm_d <= ext_sync_disarm;
      trig_d1  <= sync_in | sync_manual_req;
      trig_d2  <= trig_d1;
    end
  end

  // Armed flag with disarm over arm over trigger arrival
  always_ff @(posedge clk) begin
    if (reset || !tpl_dac_pkg::ext_sync_enable) begin
      armed <= 1'b0;
    end else if (ext_sync_disarm && !disarm_d) begin
      armed <= 1'b0;
    end else if (ext_sync_arm && !arm_d) begin
      armed <= 1'b1;
    end else if (trig_d1 && !trig_d2) begin
      armed <= 1'b0;
    end
  end

  assign sync_in_status = armed;
  assign sync_int       = armed | sync;

endmodule

//--- rtl/tpl_dac_pn.sv
// Output is the word for the current state, so the first word after restart is seed derived
`timescale 1ns/100ps

module tpl_dac_pn (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    restart,
  output tpl_dac_pkg::chan_data_t pn7_data,
  output tpl_dac_pkg::chan_data_t pn15_data
);

  logic [6:0]              pn7_state;
  logic [14:0]             pn15_state;
  tpl_dac_pkg::chan_data_t pn7_stream;
  tpl_dac_pkg::chan_data_t pn15_stream;

  // Serial LFSR x^order + x^(order-1) + 1 run for one beat, first bit in the MSB
  function automatic tpl_dac_pkg::chan_data_t lfsr_stream(input logic [14:0] state,
                                                          input int order);
    logic [14:0]             s;
    logic [14:0]             mask;
    logic                    fb;
    tpl_dac_pkg::chan_data_t stream;
    s      = state;
    mask   = (15'd1 << order) - 15'd1;
    stream = '0;
    for (int i = 0; i < tpl_dac_pkg::chan_width; i++) begin
      fb = s[order-1] ^ s[order-2];
      s  = ((s << 1) | {14'd0, fb}) & mask;
      stream[tpl_dac_pkg::chan_width-1-i] = fb;
    end
    return stream;
  endfunction

  // Earliest stream bits go to sample 0, each sample MSB first
  function automatic tpl_dac_pkg::chan_data_t pack_samples(input tpl_dac_pkg::chan_data_t stream);
    tpl_dac_pkg::chan_data_t word;
    for (int s = 0; s < tpl_dac_pkg::samples_per_beat; s++) begin
      word[s*tpl_dac_pkg::sample_width +: tpl_dac_pkg::sample_width] =
        stream[tpl_dac_pkg::chan_width-1-s*tpl_dac_pkg::sample_width -: tpl_dac_pkg::sample_width];
    end
    return word;
  endfunction

  assign pn7_stream  = lfsr_stream({8'd0, pn7_state}, 7);
  assign pn15_stream = lfsr_stream(pn15_state, 15);

  // Last bits shifted out are the state for the next beat
  always_ff @(posedge clk) begin
    if (reset || restart) begin
      pn7_state  <= tpl_dac_pkg::pn7_seed;
      pn15_state <= tpl_dac_pkg::pn15_seed;
    end else begin
      pn7_state  <= pn7_stream[6:0];
      pn15_state <= pn15_stream[14:0];
    end
  end

  assign pn7_data  = pack_samples(pn7_stream);
  assign pn15_data = pack_samples(pn15_stream);

endmodule

//--- rtl/tpl_dac_xbar_mux.sv
// Source indexes at or above the channel count give a zero word
`timescale 1ns/100ps

module tpl_dac_xbar_mux (
  input  logic                    clk,
  input  logic                    reset,
  input  tpl_dac_pkg::link_data_t data_in,
  input  tpl_dac_pkg::src_sel_t   src_sel,
  output tpl_dac_pkg::chan_data_t data_out
);

  tpl_dac_pkg::chan_data_t sel_word;

  always_comb begin
    sel_word = '0;
    for (int i = 0; i < tpl_dac_pkg::num_channels; i++) begin
      if (src_sel == i) begin
        sel_word = data_in[i*tpl_dac_pkg::chan_width +: tpl_dac_pkg::chan_width];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else begin
      data_out <= sel_word;
    end
  end

endmodule

//--- rtl/tpl_dac_channel.sv
// Source change takes effect on the next clock; enable follows data_sel without a register
`timescale 1ns/100ps

module tpl_dac_channel (
  input  logic                    clk,
  input  logic                    reset,
  input  tpl_dac_pkg::chan_data_t dma_data,
  input  tpl_dac_pkg::chan_data_t pn7_data,
  input  tpl_dac_pkg::chan_data_t pn15_data,
  input  tpl_dac_pkg::sample_t    pat_data_0,
  input  tpl_dac_pkg::sample_t    pat_data_1,
  input  tpl_dac_pkg::data_sel_t  data_sel,
  input  logic                    mask_enable,
  output tpl_dac_pkg::chan_data_t chan_data,
  output logic                    enable
);

  tpl_dac_pkg::chan_data_t next_data;

  // ********************
  // Source select
  // ********************
  always_comb begin
    case (data_sel)
      tpl_dac_pkg::sel_pattern: begin
        // Fixed two word pattern, pat_data_0 is the earlier sample
        next_data = {pat_data_1, pat_data_0};
      end
      tpl_dac_pkg::sel_dma: begin
        next_data = dma_data;
      end
      tpl_dac_pkg::sel_pn7: begin
        next_data = pn7_data;
      end
      tpl_dac_pkg::sel_pn15: begin
        next_data = pn15_data;
      end
      tpl_dac_pkg::sel_zero: begin
        next_data = '0;
      end
      default: begin
        // Reserved codes output silence
        next_data = '0;
      end
    endcase
  end

  // ********************
  // Output register
  // ********************
  always_ff @(posedge clk) begin
    if (reset) begin
      chan_data <= '0;
    end else begin
      chan_data <= next_data;
    end
  end

  // Channel consumes DMA data only when selected and not masked
  assign enable = (data_sel == tpl_dac_pkg::sel_dma) && mask_enable;

endmodule

//--- rtl/tpl_dac_framer.sv
// Channel n drives lane n, so the lane count has to match the channel count
`timescale 1ns/100ps

module tpl_dac_framer (
  input  tpl_dac_pkg::chan_data_t [tpl_dac_pkg::num_channels-1:0] chan_data,
  output tpl_dac_pkg::link_data_t                                 link_data
);

  localparam int octets_per_sample = tpl_dac_pkg::sample_width / 8;
  localparam int lane_width        = tpl_dac_pkg::octets_per_beat * 8;

  // ********************
  // Octet ordering
  // ********************
  // Within a lane, octet 0 is the high byte of sample 0,
  // then its low byte, then sample 1 high and low
  always_comb begin
    int s;
    int b;
    tpl_dac_pkg::sample_t sample;
    link_data = '0;
    for (int l = 0; l < tpl_dac_pkg::num_lanes; l++) begin
      for (int k = 0; k < tpl_dac_pkg::octets_per_beat; k++) begin
        s = k / octets_per_sample;
        b = k % octets_per_sample;
        sample = chan_data[l][s*tpl_dac_pkg::sample_width +: tpl_dac_pkg::sample_width];
        // b = 0 takes the most significant byte of the sample
        link_data[l*lane_width + k*8 +: 8] = sample[tpl_dac_pkg::sample_width-1-b*8 -: 8];
      end
    end
  end

endmodule

//--- rtl/tpl_dac_core.sv
// The DMA source must supply a word on every clock while dac_valid is high
`timescale 1ns/100ps

module tpl_dac_core (
  input  logic                                                  clk,
  input  logic                                                  reset,

  // DMA side
  input  tpl_dac_pkg::link_data_t                               dac_ddata,
  output logic [tpl_dac_pkg::num_channels-1:0]                  dac_valid,

  // Link side
  output tpl_dac_pkg::link_data_t                               link_data,

  // Sync control
  input  logic                                                  dac_sync,
  input  logic                                                  dac_sync_in,
  input  logic                                                  dac_sync_manual_req,
  input  logic                                                  dac_ext_sync_arm,
  input  logic                                                  dac_ext_sync_disarm,
  output logic                                                  dac_sync_in_status,

  // Per channel configuration
  input  tpl_dac_pkg::data_sel_t [tpl_dac_pkg::num_channels-1:0] dac_data_sel,
  input  logic [tpl_dac_pkg::num_channels-1:0]                  dac_mask_enable,
  input  tpl_dac_pkg::sample_t [tpl_dac_pkg::num_channels-1:0]  dac_pat_data_0,
  input  tpl_dac_pkg::sample_t [tpl_dac_pkg::num_channels-1:0]  dac_pat_data_1,
  input  tpl_dac_pkg::src_sel_t [tpl_dac_pkg::num_channels-1:0] dac_src_chan_sel,
  output logic [tpl_dac_pkg::num_channels-1:0]                  enable
);

  logic                                                   sync_int;
  tpl_dac_pkg::chan_data_t                                pn7_data;
  tpl_dac_pkg::chan_data_t                                pn15_data;
  tpl_dac_pkg::chan_data_t [tpl_dac_pkg::num_channels-1:0] dma_muxed;
  tpl_dac_pkg::chan_data_t [tpl_dac_pkg::num_channels-1:0] chan_data;

  // ********************
  // Sync and PN sources
  // ********************
  tpl_dac_sync i_sync (
    .clk             (clk),
    .reset           (reset),
    .sync            (dac_sync),
    .sync_in         (dac_sync_in),
    .sync_manual_req (dac_sync_manual_req),
    .ext_sync_arm    (dac_ext_sync_arm),
    .ext_sync_disarm (dac_ext_sync_disarm),
    .sync_int        (sync_int),
    .sync_in_status  (dac_sync_in_status)
  );

  // PN sequences restart from the seed whenever sync is active
  tpl_dac_pn i_pn (
    .clk       (clk),
    .reset     (reset),
    .restart   (sync_int),
    .pn7_data  (pn7_data),
    .pn15_data (pn15_data)
  );

  // DMA data is requested only outside of sync
  assign dac_valid = {tpl_dac_pkg::num_channels{~sync_int}};

  // ********************
  // Per channel datapath
  // ********************
  for (genvar i = 0; i < tpl_dac_pkg::num_channels; i++) begin : g_channel

    // Crossbar stage, first register of the DMA path
    tpl_dac_xbar_mux i_xbar_mux (
      .clk      (clk),
      .reset    (reset),
      .data_in  (dac_ddata),
      .src_sel  (dac_src_chan_sel[i]),
      .data_out (dma_muxed[i])
    );

    tpl_dac_channel i_channel (
      .clk         (clk),
      .reset       (reset),
      .dma_data    (dma_muxed[i]),
      .pn7_data    (pn7_data),
      .pn15_data   (pn15_data),
      .pat_data_0  (dac_pat_data_0[i]),
      .pat_data_1  (dac_pat_data_1[i]),
      .data_sel    (dac_data_sel[i]),
      .mask_enable (dac_mask_enable[i]),
      .chan_data   (chan_data[i]),
      .enable      (enable[i])
    );

  end

  // ********************
  // Lane packing
  // ********************
  tpl_dac_framer i_framer (
    .chan_data (chan_data),
    .link_data (link_data)
  );

endmodule

//--- verification/tpl_dac_assert.sv
// Checked on rising clk outside reset; covers only the sync, valid and enable rules of the core
`timescale 1ns/100ps

module tpl_dac_assert (
  input logic                                                   clk,
  input logic                                                   reset,
  input logic                                                   dac_sync,
  input logic [tpl_dac_pkg::num_channels-1:0]                   dac_valid,
  input logic                                                   dac_ext_sync_arm,
  input logic                                                   dac_sync_in_status,
  input tpl_dac_pkg::data_sel_t [tpl_dac_pkg::num_channels-1:0] dac_data_sel,
  input logic [tpl_dac_pkg::num_channels-1:0]                   enable
);

  // No DMA request while software sync is held
  valid_low_in_sync: assert property (
    @(posedge clk) disable iff (reset) dac_sync |-> dac_valid == '0
  ) else $error("dac_valid high while dac_sync is active");

  // Armed status only comes from a fresh arm edge one clock earlier
  status_after_arm: assert property (
    @(posedge clk) disable iff (reset)
      $rose(dac_sync_in_status) |-> $past(dac_ext_sync_arm) && !$past(dac_ext_sync_arm, 2)
  ) else $error("sync_in_status rose without an arm edge");

  for (genvar i = 0; i < tpl_dac_pkg::num_channels; i++) begin : g_enable
    enable_needs_dma: assert property (
      @(posedge clk) disable iff (reset) enable[i] |-> dac_data_sel[i] == tpl_dac_pkg::sel_dma
    ) else $error("enable set on channel %0d without DMA source", i);
  end

endmodule

bind tpl_dac_core tpl_dac_assert i_assert (
  .clk                (clk),
  .reset              (reset),
  .dac_sync           (dac_sync),
  .dac_valid          (dac_valid),
  .dac_ext_sync_arm   (dac_ext_sync_arm),
  .dac_sync_in_status (dac_sync_in_status),
  .dac_data_sel       (dac_data_sel),
  .enable             (enable)
);

//--- verification/tpl_dac_tb.sv
// Directed tests only; the DMA source is taken as always ready
`timescale 1ns/100ps

module tpl_dac_tb;

  localparam int nch = tpl_dac_pkg::num_channels;

  logic                                  clk;
  logic                                  reset;
  tpl_dac_pkg::link_data_t               dac_ddata;
  logic [nch-1:0]                        dac_valid;
  tpl_dac_pkg::link_data_t               link_data;
  logic                                  dac_sync;
  logic                                  dac_sync_in;
  logic                                  dac_sync_manual_req;
  logic                                  dac_ext_sync_arm;
  logic                                  dac_ext_sync_disarm;
  logic                                  dac_sync_in_status;
  tpl_dac_pkg::data_sel_t [nch-1:0]      dac_data_sel;
  logic [nch-1:0]                        dac_mask_enable;
  tpl_dac_pkg::sample_t [nch-1:0]        dac_pat_data_0;
  tpl_dac_pkg::sample_t [nch-1:0]        dac_pat_data_1;
  tpl_dac_pkg::src_sel_t [nch-1:0]       dac_src_chan_sel;
  logic [nch-1:0]                        enable;

  integer      seed;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;
  logic [6:0]  pn7_model;
  logic [14:0] pn15_model;

  tpl_dac_core UUT (
    .clk                 (clk),
    .reset               (reset),
    .dac_ddata           (dac_ddata),
    .dac_valid           (dac_valid),
    .link_data           (link_data),
    .dac_sync            (dac_sync),
    .dac_sync_in         (dac_sync_in),
    .dac_sync_manual_req (dac_sync_manual_req),
    .dac_ext_sync_arm    (dac_ext_sync_arm),
    .dac_ext_sync_disarm (dac_ext_sync_disarm),
    .dac_sync_in_status  (dac_sync_in_status),
    .dac_data_sel        (dac_data_sel),
    .dac_mask_enable     (dac_mask_enable),
    .dac_pat_data_0      (dac_pat_data_0),
    .dac_pat_data_1      (dac_pat_data_1),
    .dac_src_chan_sel    (dac_src_chan_sel),
    .enable              (enable)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ********************
  // Reference models
  // ********************
  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  // Octet 0 (low byte) is sample 0 high byte, then sample 0 low, sample 1 high, sample 1 low
  function automatic logic [31:0] frame_lane(input tpl_dac_pkg::chan_data_t c);
    frame_lane = {c[23:16], c[31:24], c[7:0], c[15:8]};
  endfunction

  // Rebuild the channel word of lane n from its octets
  function automatic tpl_dac_pkg::chan_data_t lane_word(input tpl_dac_pkg::link_data_t l,
                                                       input int n);
    logic [31:0]          o;
    tpl_dac_pkg::sample_t s0;
    tpl_dac_pkg::sample_t s1;
    o  = l[n*32 +: 32];
    s0 = {o[7:0], o[15:8]};
    s1 = {o[23:16], o[31:24]};
    lane_word = {s1, s0};
  endfunction

  function automatic tpl_dac_pkg::chan_data_t route(input tpl_dac_pkg::link_data_t w,
                                                    input tpl_dac_pkg::src_sel_t s);
    if (int'(s) < nch) route = w[int'(s)*32 +: 32];
    else route = '0;
  endfunction

  // One beat of both LFSR streams, first serial bit into sample 0 MSB
  task automatic pn_step(output tpl_dac_pkg::chan_data_t w7,
                         output tpl_dac_pkg::chan_data_t w15);
    logic b7;
    logic b15;
    for (int i = 0; i < 32; i++) begin
      b7         = pn7_model[6] ^ pn7_model[5];
      pn7_model  = {pn7_model[5:0], b7};
      b15        = pn15_model[14] ^ pn15_model[13];
      pn15_model = {pn15_model[13:0], b15};
      if (i < 16) begin
        w7[15-i]  = b7;
        w15[15-i] = b15;
      end else begin
        w7[47-i]  = b7;
        w15[47-i] = b15;
      end
    end
  endtask

  // ********************
  // Compare and report
  // ********************
  task automatic check_link(input string name, input tpl_dac_pkg::link_data_t expected,
                            input tpl_dac_pkg::link_data_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_chan(input string name, input tpl_dac_pkg::chan_data_t expected,
                            input tpl_dac_pkg::chan_data_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
      errors++;
    end
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", name, errors - errors_at_start);
    end
  endtask

  // Polls at the falling edge until the armed status reaches the wanted level
  task automatic wait_status(input string name, input logic expected, input int max_cycles);
    int n;
    n = 0;
    while (dac_sync_in_status !== expected && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (dac_sync_in_status !== expected) begin
      $display("%s: sync_in_status did not reach %b within %0d clocks", name, expected,
               max_cycles);
      errors++;
    end
  endtask

  // ********************
  // Directed tests
  // ********************
  task automatic test_reset_state();
    begin_test();
    check_link("reset_state", '0, link_data);
    check_bit("reset_state", 1'b1, &dac_valid);
    check_bit("reset_state", 1'b0, dac_sync_in_status);
    end_test("reset_state");
  endtask

  task automatic test_pattern();
    logic [31:0]             r0;
    logic [31:0]             r1;
    tpl_dac_pkg::link_data_t expected;
    begin_test();
    for (int n = 0; n < 4; n++) begin
      r0 = rand_word();
      r1 = rand_word();
      @(posedge clk);
      dac_data_sel   <= {tpl_dac_pkg::sel_pattern, tpl_dac_pkg::sel_pattern};
      dac_pat_data_0 <= r0;
      dac_pat_data_1 <= r1;
      @(posedge clk);
      @(negedge clk);
      expected = {frame_lane({r1[31:16], r0[31:16]}), frame_lane({r1[15:0], r0[15:0]})};
      check_link("pattern", expected, link_data);
    end
    end_test("pattern");
  endtask

  // Each word must show up two clocks after it is driven, routed and framed
  task automatic run_dma_stream(input string name, input tpl_dac_pkg::src_sel_t s0,
                                input tpl_dac_pkg::src_sel_t s1, input int count);
    tpl_dac_pkg::link_data_t words [16];
    tpl_dac_pkg::link_data_t expected;
    for (int j = 0; j < count + 2; j++) begin
      @(posedge clk);
      if (j == 0) dac_src_chan_sel <= {s1, s0};
      if (j < count) begin
        words[j] = {rand_word(), rand_word()};
        dac_ddata <= words[j];
      end
      @(negedge clk);
      if (j >= 2) begin
        expected = {frame_lane(route(words[j-2], s1)), frame_lane(route(words[j-2], s0))};
        check_link(name, expected, link_data);
      end
    end
  endtask

  task automatic test_dma();
    begin_test();
    @(posedge clk);
    dac_data_sel    <= {tpl_dac_pkg::sel_dma, tpl_dac_pkg::sel_dma};
    dac_mask_enable <= 2'b11;
    run_dma_stream("dma_identity", 8'd0, 8'd1, 8);
    run_dma_stream("dma_swapped", 8'd1, 8'd0, 8);
    run_dma_stream("dma_out_of_range", 8'd2, 8'd1, 6);
    end_test("dma");
  endtask

  task automatic test_zero_enable();
    begin_test();
    @(posedge clk);
    dac_data_sel     <= {4'd9, tpl_dac_pkg::sel_zero};
    dac_mask_enable  <= 2'b11;
    dac_src_chan_sel <= {8'd1, 8'd0};
    @(negedge clk);
    check_bit("zero_enable", 1'b0, enable[0]);
    check_bit("zero_enable", 1'b0, enable[1]);
    // Both crossbar outputs carry nonzero DMA words by the second clock
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_link("zero_enable", '0, link_data);
    @(posedge clk);
    dac_data_sel    <= {tpl_dac_pkg::sel_dma, tpl_dac_pkg::sel_dma};
    dac_mask_enable <= 2'b01;
    @(negedge clk);
    check_bit("zero_enable", 1'b1, enable[0]);
    check_bit("zero_enable", 1'b0, enable[1]);
    @(posedge clk);
    dac_data_sel    <= {tpl_dac_pkg::sel_dma, tpl_dac_pkg::sel_pn7};
    dac_mask_enable <= 2'b11;
    @(negedge clk);
    check_bit("zero_enable", 1'b0, enable[0]);
    check_bit("zero_enable", 1'b1, enable[1]);
    end_test("zero_enable");
  endtask

  task automatic test_pn();
    tpl_dac_pkg::chan_data_t w7;
    tpl_dac_pkg::chan_data_t w15;
    begin_test();
    @(posedge clk);
    dac_data_sel <= {tpl_dac_pkg::sel_pn15, tpl_dac_pkg::sel_pn7};
    dac_sync     <= 1'b1;
    @(negedge clk);
    check_bit("pn_sync_valid", 1'b0, |dac_valid);
    @(posedge clk);
    @(posedge clk);
    dac_sync <= 1'b0;
    @(negedge clk);
    check_bit("pn_sync_valid", 1'b1, &dac_valid);
    pn7_model  = 7'h7f;
    pn15_model = 15'h7fff;
    for (int k = 0; k < 20; k++) begin
      @(posedge clk);
      @(negedge clk);
      pn_step(w7, w15);
      check_chan("pn7", w7, lane_word(link_data, 0));
      check_chan("pn15", w15, lane_word(link_data, 1));
    end
    end_test("pn");
  endtask

  task automatic arm_and_check(input string name);
    @(posedge clk);
    dac_ext_sync_arm <= 1'b1;
    @(posedge clk);
    dac_ext_sync_arm <= 1'b0;
    @(negedge clk);
    check_bit(name, 1'b1, dac_sync_in_status);
    check_bit(name, 1'b0, |dac_valid);
  endtask

  task automatic test_ext_sync();
    begin_test();
    // Trigger through sync_in
    arm_and_check("ext_arm");
    @(posedge clk);
    dac_sync_in <= 1'b1;
    @(negedge clk);
    wait_status("ext_sync_in", 1'b0, 4);
    check_bit("ext_sync_in", 1'b1, &dac_valid);
    @(posedge clk);
    dac_sync_in <= 1'b0;
    repeat (2) @(posedge clk);
    // Disarm before any trigger
    arm_and_check("ext_arm_again");
    @(posedge clk);
    dac_ext_sync_disarm <= 1'b1;
    @(posedge clk);
    dac_ext_sync_disarm <= 1'b0;
    @(negedge clk);
    check_bit("ext_disarm", 1'b0, dac_sync_in_status);
    check_bit("ext_disarm", 1'b1, &dac_valid);
    // Manual request acts as the trigger
    arm_and_check("ext_arm_manual");
    @(posedge clk);
    dac_sync_manual_req <= 1'b1;
    @(negedge clk);
    wait_status("ext_manual_req", 1'b0, 4);
    check_bit("ext_manual_req", 1'b1, &dac_valid);
    @(posedge clk);
    dac_sync_manual_req <= 1'b0;
    repeat (2) @(posedge clk);
    end_test("ext_sync");
  endtask

  initial begin
    seed                = 1031;
    errors              = 0;
    errors_at_start     = 0;
    tests_run           = 0;
    tests_failed        = 0;
    reset               = 1'b1;
    dac_ddata           = '0;
    dac_sync            = 1'b0;
    dac_sync_in         = 1'b0;
    dac_sync_manual_req = 1'b0;
    dac_ext_sync_arm    = 1'b0;
    dac_ext_sync_disarm = 1'b0;
    dac_data_sel        = {tpl_dac_pkg::sel_zero, tpl_dac_pkg::sel_zero};
    dac_mask_enable     = '0;
    dac_pat_data_0      = '0;
    dac_pat_data_1      = '0;
    dac_src_chan_sel    = {8'd1, 8'd0};
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_reset_state();
    test_pattern();
    test_dma();
    test_zero_enable();
    test_pn();
    test_ext_sync();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
common/tpl_dac_pkg.sv
rtl/tpl_dac_sync.sv
rtl/tpl_dac_pn.sv
rtl/tpl_dac_xbar_mux.sv
rtl/tpl_dac_channel.sv
rtl/tpl_dac_framer.sv
rtl/tpl_dac_core.sv
verification/tpl_dac_assert.sv
verification/tpl_dac_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then decide on the log contents

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tpl_dac_tb \
  -Mdir obj_dir -o tpl_dac_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/tpl_dac_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^test passed$" "$SIM_LOG"; then
  echo "Simulation PASS"
  exit 0
else
  echo "Simulation FAIL, see $SIM_LOG"
  exit 1
fi
